// ==== alu.sv ====
`timescale 1ns/1ps

module alu import mips_pkg::*; (
	input  alu_op_t     op,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	output logic [31:0] y,
	output logic        zero
);

	logic [31:0] diff;
	logic        lt_signed;
	logic        lt_unsigned;

	assign diff        = a - b;
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	// Equality for BEQ and BNE, independent of op
	assign zero = (diff == 32'd0);

	always_comb begin
		case (op)
			ALU_ADD:  y = a + b;
			ALU_SUB:  y = diff;
			ALU_AND:  y = a & b;
			ALU_OR:   y = a | b;
			ALU_XOR:  y = a ^ b;
			ALU_SLT:  y = {31'd0, lt_signed};
			ALU_SLTU: y = {31'd0, lt_unsigned};
			ALU_SLL:  y = b << shamt; // rt shifted, rs unused
			ALU_SRL:  y = b >> shamt; // Logical, zero fill
			ALU_LUI:  y = {b[15:0], 16'd0};
			default:  y = 32'd0; // Unused encodings
		endcase
	end

endmodule

// ==== control_unit.sv ====
`timescale 1ns/1ps
`include "mips_defines.svh"

module control_unit import mips_pkg::*; (
	input  logic [31:0] instr,
	output ctrl_t       ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rt;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rt     = instr[20:16];

	always_comb begin
		// NOP bundle unless a code below matches
		ctrl.reg_write    = 1'b0;
		ctrl.dest_sel     = DEST_RT;
		ctrl.alu_src_imm  = 1'b0;
		ctrl.imm_zero_ext = 1'b0;
		ctrl.mem_read     = 1'b0;
		ctrl.mem_write    = 1'b0;
		ctrl.branch_ne    = 1'b0;
		ctrl.wb_sel       = WB_ALU;
		ctrl.pc_sel       = PC_SEQ;
		ctrl.alu_op       = ALU_ADD;

		case (opcode)
			`OP_RTYPE: begin
				ctrl.dest_sel = DEST_RD; // Result goes to rd
				ctrl.reg_write = 1'b1;
				case (funct)
					`FN_ADDU: ctrl.alu_op = ALU_ADD;
					`FN_SUBU: ctrl.alu_op = ALU_SUB;
					`FN_AND:  ctrl.alu_op = ALU_AND;
					`FN_OR:   ctrl.alu_op = ALU_OR;
					`FN_XOR:  ctrl.alu_op = ALU_XOR;
					`FN_SLT:  ctrl.alu_op = ALU_SLT;
					`FN_SLTU: ctrl.alu_op = ALU_SLTU;
					`FN_SLL:  ctrl.alu_op = ALU_SLL; // Shift by shamt field
					`FN_SRL:  ctrl.alu_op = ALU_SRL;
					`FN_JR: begin
						ctrl.reg_write = 1'b0; // No link
						ctrl.pc_sel    = PC_REG; // PC from rs
					end
					default: ctrl.reg_write = 1'b0; // Unknown funct is a NOP
				endcase
			end
			`OP_ADDIU: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1; // Sign-extended immediate
				ctrl.alu_op      = ALU_ADD;
			end
			`OP_SLTI, `OP_SLTIU: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1; // Both compare a sign-extended immediate
				ctrl.alu_op      = (opcode == `OP_SLTI) ? ALU_SLT : ALU_SLTU;
			end
			`OP_ANDI, `OP_ORI, `OP_XORI: begin
				ctrl.reg_write    = 1'b1;
				ctrl.alu_src_imm  = 1'b1;
				ctrl.imm_zero_ext = 1'b1; // Logic immediates are zero extended
				case (opcode)
					`OP_ANDI: ctrl.alu_op = ALU_AND;
					`OP_ORI:  ctrl.alu_op = ALU_OR;
					default:  ctrl.alu_op = ALU_XOR;
				endcase
			end
			`OP_LUI: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = ALU_LUI; // Immediate into upper half
			end
			`OP_LW: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1; // Base plus offset
				ctrl.mem_read    = 1'b1;
				ctrl.wb_sel      = WB_LOAD;
			end
			`OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1; // Store data is rt
			end
			`OP_BEQ, `OP_BNE: begin
				ctrl.alu_op    = ALU_SUB; // Zero flag compares rs and rt
				ctrl.pc_sel    = PC_BRANCH;
				ctrl.branch_ne = (opcode == `OP_BNE);
			end
			`OP_J: ctrl.pc_sel = PC_JUMP;
			`OP_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel  = DEST_RA; // Link in register 31
				ctrl.wb_sel    = WB_LINK;
				ctrl.pc_sel    = PC_JUMP;
			end
			default: ; // Unsupported opcode, keep NOP bundle
		endcase

		// I-type writes that name register zero are dropped here
		if (ctrl.dest_sel == DEST_RT && rt == 5'd0)
			ctrl.reg_write = 1'b0;
	end

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ps
`include "mips_defines.svh"

module datapath import mips_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	input  ctrl_t       ctrl,
	input  logic [31:0] instr,
	input  logic [31:0] load_data,
	output logic [31:0] pc,
	output logic [31:0] mem_address,
	output logic [31:0] mem_wdata,
	output logic        mem_read,
	output logic        mem_write,
	output logic [31:0] v0,
	output logic        active
);

	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [4:0]  shamt;
	logic [15:0] imm16;
	logic [25:0] target;

	logic [31:0] imm_sign;
	logic [31:0] imm_ext;
	logic [4:0]  dest;
	logic [31:0] wb_data;
	logic        rf_we;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] alu_b;
	logic [31:0] alu_y;
	logic        alu_zero;

	logic [31:0] pc_plus4;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic        branch_taken;
	logic [31:0] next_pc;

	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign shamt  = instr[10:6];
	assign imm16  = instr[15:0];
	assign target = instr[25:0];

	assign imm_sign = {{16{imm16[15]}}, imm16};
	assign imm_ext  = ctrl.imm_zero_ext ? {16'd0, imm16} : imm_sign; // ANDI, ORI, XORI

	always_comb begin
		case (ctrl.dest_sel)
			DEST_RD: dest = rd;
			DEST_RA: dest = 5'd31; // JAL link
			default: dest = rt;
		endcase
	end

	always_comb begin
		case (ctrl.wb_sel)
			WB_LOAD: wb_data = load_data;
			WB_LINK: wb_data = pc_plus4; // No delay slot, return to next word
			default: wb_data = alu_y;
		endcase
	end

	// Commit only on an enabled edge while running
	assign rf_we = ctrl.reg_write && active && clk_enable;

	reg_file rf0 (
		.clk   (clk),
		.reset (reset),
		.we    (rf_we),
		.ra1   (rs),
		.ra2   (rt),
		.wa    (dest),
		.wd    (wb_data),
		.rd1   (rs_val),
		.rd2   (rt_val),
		.v0    (v0)
	);

	assign alu_b = ctrl.alu_src_imm ? imm_ext : rt_val;

	alu alu0 (
		.op    (ctrl.alu_op),
		.a     (rs_val),
		.b     (alu_b),
		.shamt (shamt),
		.y     (alu_y),
		.zero  (alu_zero)
	);

	// Memory port, masked after halt
	assign mem_address = alu_y;
	assign mem_wdata   = rt_val;
	assign mem_read    = ctrl.mem_read && active;
	assign mem_write   = ctrl.mem_write && active;

	// Next-PC candidates
	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm_sign[29:0], 2'b00}; // Word offset
	assign jump_target   = {pc_plus4[31:28], target, 2'b00};
	assign branch_taken  = alu_zero ^ ctrl.branch_ne; // BEQ on zero, BNE on not-zero

	always_comb begin
		case (ctrl.pc_sel)
			PC_BRANCH: next_pc = branch_taken ? branch_target : pc_plus4;
			PC_JUMP:   next_pc = jump_target;
			PC_REG:    next_pc = rs_val; // JR
			default:   next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc     <= `RESET_VECTOR;
			active <= 1'b1;
		end else if (clk_enable && active) begin
			pc <= next_pc;
			if (next_pc == `HALT_ADDRESS)
				active <= 1'b0; // PC then parks at the halt address
		end
	end

endmodule

// ==== mips_cpu_asserts.sv ====
`timescale 1ns/1ps

module mips_cpu_asserts (
	input logic clk,
	input logic reset,
	input logic active,
	input logic data_read,
	input logic data_write
);

	// One memory access per cycle
	read_write_excl: assert property (
		@(posedge clk) disable iff (reset)
		!(data_read && data_write)
	) else $error("data_read and data_write high together");

	// Stores masked once halted
	no_write_halted: assert property (
		@(posedge clk) disable iff (reset)
		!active |-> !data_write
	) else $error("data_write high while not active");

	// Halt is sticky until reset
	halt_sticky: assert property (
		@(posedge clk) disable iff (reset)
		!active |=> !active
	) else $error("active rose again without reset");

endmodule

// ==== mips_cpu_harvard.sv ====
`timescale 1ns/1ps

module mips_cpu_harvard import mips_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	output logic        active,
	output logic [31:0] register_v0,
	output logic [31:0] instr_address,  // Current PC
	input  logic [31:0] instr_readdata, // Same-cycle fetch
	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata   // Same-cycle load
);

	ctrl_t ctrl; // Decoded bundle for the current instruction

	control_unit cu0 (
		.instr (instr_readdata),
		.ctrl  (ctrl)
	);

	datapath dp0 (
		.clk         (clk),
		.reset       (reset),
		.clk_enable  (clk_enable),
		.ctrl        (ctrl),
		.instr       (instr_readdata),
		.load_data   (data_readdata),
		.pc          (instr_address),
		.mem_address (data_address),
		.mem_wdata   (data_writedata),
		.mem_read    (data_read),
		.mem_write   (data_write),
		.v0          (register_v0),
		.active      (active)
	);

endmodule

// ==== mips_cpu_tb.sv ====
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_cpu_tb;

	localparam int PROG_LEN   = 200; // Words of generated program
	localparam int RESET_CYC  = 8;
	localparam int CYC_LIMIT  = 2 * PROG_LEN * 4 + RESET_CYC; // Stalls included

	logic        clk;
	logic        reset;
	logic        clk_enable;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] data_address;
	logic        data_write;
	logic        data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;

	logic [31:0] imem [256];
	logic [31:0] dmem [64];   // DUT side data memory
	logic [31:0] m_dmem [64]; // Model copy
	logic [31:0] m_regs [32];
	logic [31:0] m_pc;
	logic        m_active;

	int    errs [6];
	string names [6];
	int    cycles;
	bit    timed_out;

	mips_cpu_harvard dut0 (.*);

	bind mips_cpu_harvard mips_cpu_asserts asrt0 (
		.clk        (clk),
		.reset      (reset),
		.active     (active),
		.data_read  (data_read),
		.data_write (data_write)
	);

	always #20 clk = ~clk; // 40 ns period

	// Combinational memories
	always_comb begin
		if (instr_address >= `RESET_VECTOR && instr_address < `RESET_VECTOR + 32'd1024)
			instr_readdata = imem[(instr_address - `RESET_VECTOR) >> 2];
		else
			instr_readdata = {`OP_SW, 5'd0, 5'd2, 16'd0}; // Store, masked once halted
	end
	assign data_readdata = dmem[data_address[7:2]];

	always @(posedge clk) begin
		if (data_write && clk_enable)
			dmem[data_address[7:2]] <= data_writedata;
	end

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {`OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input int idx);
		logic [31:0] addr;
		addr = `RESET_VECTOR + 32'(idx) * 4;
		return {op, addr[27:2]};
	endfunction

	function automatic logic [4:0] pick_reg();
		if ($urandom % 3 == 0)
			return 5'd2; // Bias toward v0
		return 5'(1 + $urandom % 7);
	endfunction

	task automatic gen_program();
		logic [5:0] r_fn [9];
		logic [5:0] i_op [7];
		int i;
		int kind;
		int k;
		r_fn = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT, `FN_SLTU,
			`FN_SLL, `FN_SRL};
		i_op = '{`OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_SLTI, `OP_SLTIU, `OP_LUI};
		for (int j = 0; j < 256; j++)
			imem[j] = 32'd0;
		i = 0;
		while (i < PROG_LEN - 1) begin
			kind = $urandom % 10;
			if (kind < 4) begin
				k = $urandom % 9;
				if (k >= 7) // Shifts read rt only
					imem[i] = enc_r(5'd0, pick_reg(), pick_reg(), 5'($urandom), r_fn[k]);
				else
					imem[i] = enc_r(pick_reg(), pick_reg(), pick_reg(), 5'd0, r_fn[k]);
			end else if (kind < 6) begin
				imem[i] = enc_i(i_op[$urandom % 7], pick_reg(), pick_reg(), 16'($urandom));
			end else if (kind == 6) begin
				imem[i] = enc_i(($urandom % 2) ? `OP_LW : `OP_SW, 5'd0, pick_reg(),
					16'(($urandom % 64) * 4)); // Base zero, aligned
			end else if (kind == 7 && i + 4 < PROG_LEN - 1) begin
				imem[i] = enc_i(($urandom % 2) ? `OP_BNE : `OP_BEQ, pick_reg(), pick_reg(),
					16'($urandom % 4));
			end else if (kind == 8 && i + 4 < PROG_LEN - 1) begin
				imem[i] = enc_j(`OP_J, i + 1 + $urandom % 4); // Forward only
			end else if (kind == 9 && i + 2 < PROG_LEN - 1) begin
				imem[i] = enc_j(`OP_JAL, i + 1);
				i++;
				imem[i] = enc_r(5'd31, 5'd0, 5'd2, 5'd0, `FN_ADDU); // Link into v0
			end else begin
				imem[i] = enc_i(`OP_ADDIU, pick_reg(), pick_reg(), 16'($urandom));
			end
			i++;
		end
		imem[PROG_LEN - 1] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, `FN_JR); // Jump to zero
	endtask

	function automatic logic [31:0] fetch(input logic [31:0] addr);
		if (addr >= `RESET_VECTOR && addr < `RESET_VECTOR + 32'd1024)
			return imem[(addr - `RESET_VECTOR) >> 2];
		return 32'd0;
	endfunction

	task automatic wr_reg(input logic [4:0] idx, input logic [31:0] val);
		if (idx != 5'd0)
			m_regs[idx] = val;
	endtask

	// Reference ISA step, no delay slot
	task automatic model_step();
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [31:0] nxt;
		logic [31:0] addr;
		ins  = fetch(m_pc);
		a    = m_regs[ins[25:21]];
		b    = m_regs[ins[20:16]];
		simm = {{16{ins[15]}}, ins[15:0]};
		zimm = {16'd0, ins[15:0]};
		nxt  = m_pc + 4;
		addr = a + simm;
		case (ins[31:26])
			`OP_RTYPE: case (ins[5:0])
				`FN_ADDU: wr_reg(ins[15:11], a + b);
				`FN_SUBU: wr_reg(ins[15:11], a - b);
				`FN_AND:  wr_reg(ins[15:11], a & b);
				`FN_OR:   wr_reg(ins[15:11], a | b);
				`FN_XOR:  wr_reg(ins[15:11], a ^ b);
				`FN_SLT:  wr_reg(ins[15:11], {31'd0, $signed(a) < $signed(b)});
				`FN_SLTU: wr_reg(ins[15:11], {31'd0, a < b});
				`FN_SLL:  wr_reg(ins[15:11], b << ins[10:6]);
				`FN_SRL:  wr_reg(ins[15:11], b >> ins[10:6]);
				`FN_JR:   nxt = a;
				default: ;
			endcase
			`OP_ADDIU: wr_reg(ins[20:16], a + simm);
			`OP_ANDI:  wr_reg(ins[20:16], a & zimm);
			`OP_ORI:   wr_reg(ins[20:16], a | zimm);
			`OP_XORI:  wr_reg(ins[20:16], a ^ zimm);
			`OP_SLTI:  wr_reg(ins[20:16], {31'd0, $signed(a) < $signed(simm)});
			`OP_SLTIU: wr_reg(ins[20:16], {31'd0, a < simm});
			`OP_LUI:   wr_reg(ins[20:16], {ins[15:0], 16'd0});
			`OP_LW:    wr_reg(ins[20:16], m_dmem[addr[7:2]]);
			`OP_SW:    m_dmem[addr[7:2]] = b;
			`OP_BEQ:   if (a == b) nxt = m_pc + 4 + (simm << 2);
			`OP_BNE:   if (a != b) nxt = m_pc + 4 + (simm << 2);
			`OP_J:     nxt = {nxt[31:28], ins[25:0], 2'b00};
			`OP_JAL: begin
				wr_reg(5'd31, m_pc + 4);
				nxt = {nxt[31:28], ins[25:0], 2'b00};
			end
			default: ;
		endcase
		m_pc = nxt;
		if (nxt == `HALT_ADDRESS)
			m_active = 1'b0;
	endtask

	task automatic check_val(input int t, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("** Error %s (%s): expected %h, actual %h", names[t], what, exp, act);
			errs[t]++;
		end
	endtask

	// Compares port outputs against the model before the edge
	task automatic check_cycle();
		logic [31:0] ins;
		logic [31:0] addr;
		logic        is_lw;
		logic        is_sw;
		ins   = fetch(m_pc);
		addr  = m_regs[ins[25:21]] + {{16{ins[15]}}, ins[15:0]};
		is_lw = (ins[31:26] == `OP_LW);
		is_sw = (ins[31:26] == `OP_SW);
		check_val(3, "instr_address", m_pc, instr_address);
		check_val(1, "register_v0", m_regs[2], register_v0);
		check_val(2, "data_read", 32'(is_lw), 32'(data_read));
		check_val(2, "data_write", 32'(is_sw), 32'(data_write));
		if (is_lw || is_sw)
			check_val(2, "data_address", addr, data_address);
		if (is_sw)
			check_val(2, "data_writedata", m_regs[ins[20:16]], data_writedata);
		if (!active) begin
			$display("** Error %s: active went low before the final jump", names[3]);
			errs[3]++;
		end
	endtask

	initial begin
		logic [31:0] snap [6];
		logic        prev_en;
		int          npass;
		names = '{"reset_state", "alu_results", "memory_access", "control_flow",
			"stall", "halt"};
		clk        = 1'b0;
		reset      = 1'b1;
		clk_enable = 1'b0;
		timed_out  = 1'b0;
		cycles     = 0;
		prev_en    = 1'b1;
		void'($urandom(28510));
		for (int i = 0; i < 6; i++)
			errs[i] = 0;
		gen_program();
		for (int i = 0; i < 64; i++) begin
			dmem[i]   = 32'(i) * 32'h9E37_79B1 ^ {26'd0, 6'(i)}; // Depends on every bit
			m_dmem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++)
			m_regs[i] = 32'd0;
		m_pc     = `RESET_VECTOR;
		m_active = 1'b1;

		repeat (RESET_CYC) @(posedge clk);
		#2 reset = 1'b0;
		@(negedge clk);
		check_val(0, "instr_address", `RESET_VECTOR, instr_address);
		check_val(0, "active", 32'd1, 32'(active));
		check_val(0, "register_v0", 32'd0, register_v0);
		check_val(0, "data_read", 32'd0, 32'(data_read));
		check_val(0, "data_write", 32'd0, 32'(data_write));
		@(posedge clk);

		while (m_active && cycles < CYC_LIMIT) begin
			#2 clk_enable = ($urandom % 4 != 0); // Roughly one stall in four
			@(negedge clk);
			check_cycle();
			if (!prev_en) begin // Previous edge was ignored
				check_val(4, "instr_address", snap[0], instr_address);
				check_val(4, "register_v0", snap[1], register_v0);
				check_val(4, "data_address", snap[2], data_address);
				check_val(4, "data_read", snap[3], 32'(data_read));
				check_val(4, "data_write", snap[4], 32'(data_write));
				check_val(4, "data_writedata", snap[5], data_writedata);
			end
			snap[0] = instr_address;
			snap[1] = register_v0;
			snap[2] = data_address;
			snap[3] = 32'(data_read);
			snap[4] = 32'(data_write);
			snap[5] = data_writedata;
			prev_en = clk_enable;
			if (clk_enable)
				model_step();
			@(posedge clk);
			cycles++;
		end

		if (m_active) begin
			$display("Timeout: program did not reach the halt address in %0d cycles", cycles);
			timed_out = 1'b1;
		end else begin
			repeat (11) begin
				#2 clk_enable = $urandom % 2;
				@(negedge clk);
				check_val(5, "active", 32'd0, 32'(active));
				check_val(5, "instr_address", `HALT_ADDRESS, instr_address);
				check_val(5, "data_write", 32'd0, 32'(data_write));
				@(posedge clk);
			end
		end

		npass = 0;
		for (int i = 0; i < 6; i++) begin
			$display("test %-14s %s (%0d errors)", names[i], errs[i] == 0 ? "ok" : "FAILED",
				errs[i]);
			if (errs[i] == 0)
				npass++;
		end
		$display("tests: %0d passed, %0d failed, %0d cycles", npass, 6 - npass, cycles);
		if (npass == 6 && !timed_out) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Fetch addresses
`define RESET_VECTOR 32'hBFC0_0000 // First fetch after reset
`define HALT_ADDRESS 32'h0000_0000 // Jump here ends execution

// Primary opcodes, instr[31:26]
`define OP_RTYPE 6'b000000 // Decoded further by funct
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_ADDIU 6'b001001
`define OP_SLTI  6'b001010
`define OP_SLTIU 6'b001011
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_XORI  6'b001110
`define OP_LUI   6'b001111
`define OP_LW    6'b100011
`define OP_SW    6'b101011

// Funct codes for OP_RTYPE, instr[5:0]
`define FN_SLL  6'b000000
`define FN_SRL  6'b000010
`define FN_JR   6'b001000
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

`endif

// ==== mips_pkg.sv ====
package mips_pkg;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0, // a + b, also load/store address
		ALU_SUB  = 4'd1, // a - b
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5, // Signed compare
		ALU_SLTU = 4'd6, // Unsigned compare
		ALU_SLL  = 4'd7, // b << shamt
		ALU_SRL  = 4'd8, // b >> shamt, zero fill
		ALU_LUI  = 4'd9  // b << 16
	} alu_op_t;

	typedef enum logic [1:0] {
		WB_ALU  = 2'd0, // ALU result
		WB_LOAD = 2'd1, // Data memory read data
		WB_LINK = 2'd2  // PC + 4 for JAL
	} wb_sel_t;

	typedef enum logic [1:0] {
		PC_SEQ    = 2'd0, // PC + 4
		PC_BRANCH = 2'd1, // Conditional, PC + 4 + offset
		PC_JUMP   = 2'd2, // Region of PC + 4 with 26-bit target
		PC_REG    = 2'd3  // Value of rs
	} pc_sel_t;

	typedef enum logic [1:0] {
		DEST_RT = 2'd0, // I-type destination
		DEST_RD = 2'd1, // R-type destination
		DEST_RA = 2'd2  // Register 31 for JAL
	} dest_sel_t;

	typedef struct packed {
		logic      reg_write;    // Register file write
		dest_sel_t dest_sel;     // Destination register select
		logic      alu_src_imm;  // ALU b from immediate
		logic      imm_zero_ext; // Zero extend instead of sign extend
		logic      mem_read;     // LW
		logic      mem_write;    // SW
		logic      branch_ne;    // Branch on not-zero (BNE)
		wb_sel_t   wb_sel;       // Write-back source
		pc_sel_t   pc_sel;       // Next-PC source
		alu_op_t   alu_op;       // ALU operation
	} ctrl_t;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic        clk,
	input  logic        reset,
	input  logic        we,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	output logic [31:0] v0
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0; // Known start for the model
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd; // Register zero never written
		end
	end

	// Combinational reads, register zero stays zero
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];
	assign v0  = regs[2];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mips_cpu_tb -f src.f \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vmips_cpu_tb > sim.log 2>&1 || true
cat sim.log
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== src.f ====
+incdir+.
mips_pkg.sv
control_unit.sv
alu.sv
reg_file.sv
datapath.sv
mips_cpu_harvard.sv
mips_cpu_asserts.sv
mips_cpu_tb.sv
